//--- tb.f
hw/ts_pkg.sv
hw/ts_sprite_decode.sv
hw/ts_render.sv
hw/ts_line_buf.sv
hw/ts_line_top.sv
dv/ts_dram_model.sv
dv/ts_tb.sv

//--- Makefile
# Verilator build and run for the sprite line renderer

VERILATOR ?= verilator
TOP       ?= ts_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ts_tb.sv
module ts_tb
    import ts_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // 12 line sweeps (clears and scans), 6 renders, register traffic per test
    localparam int SWEEPS  = 12;
    localparam int RENDERS = 6;
    localparam int TESTS   = 6;
    localparam int TIMEOUT = SWEEPS * 520 + RENDERS * (16 * 8 + 20) + TESTS * 100;

    logic       clk;
    logic       reset;
    axi_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    logic       wvalid;
    logic       wready;
    axi_resp_t  bresp;
    logic       bvalid;
    logic       bready;
    axi_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    axi_data_t  rdata;
    axi_resp_t  rresp;
    logic       rvalid;
    logic       rready;
    dram_addr_t dram_addr;
    logic       dram_req;
    dram_data_t dram_rdata;
    logic       dram_next;
    xcoord_t    scan_addr;
    color_t     scan_data;

    // expected line buffer
    color_t  img [512];
    int      seed = 32'h8ae5_41ad;
    int      checks = 0;
    int      errors = 0;
    int      cycles = 0;
    logic    scan_on;
    logic    scan_on_d = 1'b0;
    xcoord_t scan_addr_d;

    ts_line_top UUT (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .dram_addr  (dram_addr),
        .dram_req   (dram_req),
        .dram_rdata (dram_rdata),
        .dram_next  (dram_next),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data)
    );

    ts_dram_model dram (
        .clk        (clk),
        .reset      (reset),
        .dram_addr  (dram_addr),
        .dram_req   (dram_req),
        .dram_rdata (dram_rdata),
        .dram_next  (dram_next)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT never went idle", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_color(input string name, input color_t got, input color_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %02h expected %02h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %01h expected %01h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input axi_data_t got, input axi_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %08h expected %08h", name, got, exp);
        end
    endtask

    // scan data lands one cycle after its address and is compared mid-cycle
    always @(posedge clk) begin
        scan_on_d   <= scan_on;
        scan_addr_d <= scan_addr;
    end

    always @(negedge clk) begin
        if (scan_on_d) begin
            check_color($sformatf("scan_data[%0d]", scan_addr_d), scan_data,
                        img[scan_addr_d]);
        end
    end

    function automatic dram_data_t dram_word(input dram_addr_t a);
        logic [31:0] prod;
        prod = {11'b0, a} * 32'h0000_9e37;
        return prod[15:0] ^ 16'h5a5a;
    endfunction

    // expected effect of one sprite on the line
    function automatic void render_ref(input xcoord_t x, input xsize_t size,
            input logic flip, input page_t page, input bmp_line_t line,
            input word_addr_t addr, input pal_t pal);
        int         width;
        int         w;
        int         p;
        int         k;
        int         pos;
        page_t      pg;
        word_addr_t wa;
        dram_data_t d;
        pix_t       nib [4];
        width = 8 * (int'(size) + 1);
        // upper line bits land in the page
        pg = page + {5'b0, line[8:6]};
        wa = addr;
        for (w = 0; w < width / 4; w++) begin
            d = dram_word({pg, line[5:0], wa});
            nib[0] = d[7:4];
            nib[1] = d[3:0];
            nib[2] = d[15:12];
            nib[3] = d[11:8];
            for (p = 0; p < 4; p++) begin
                k = w * 4 + p;
                // mirrored from the right edge when flipped
                pos = flip ? int'(x) + width - 1 - k : int'(x) + k;
                if (nib[p] != 4'h0) begin
                    img[pos % 512] = {pal, nib[p]};
                end
            end
            wa = wa + 7'd1;
        end
    endfunction

    function automatic void clear_img();
        for (int i = 0; i < 512; i++) begin
            img[i] = '0;
        end
    endfunction

    // all bus tasks start and end on a rising edge
    task automatic axi_write(input axi_addr_t a, input axi_data_t d, output axi_resp_t resp);
        awaddr  <= a;
        wdata   <= d;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
    endtask

    task automatic axi_read(input axi_addr_t a, output axi_data_t d);
        araddr  <= a;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        d = rdata;
        check_resp("rresp", rresp, RESP_OKAY);
        @(posedge clk);
    endtask

    task automatic write_reg(input axi_addr_t a, input axi_data_t d);
        axi_resp_t resp;
        axi_write(a, d, resp);
        check_resp("bresp", resp, RESP_OKAY);
    endtask

    task automatic ctrl_write(input axi_data_t d, input axi_resp_t exp);
        axi_resp_t resp;
        axi_write(REG_CTRL, d, resp);
        check_resp("bresp", resp, exp);
    endtask

    // poll status until render and clear are both done
    task automatic wait_idle();
        axi_data_t st;
        do axi_read(REG_CTRL, st); while (st[1:0] != 2'b00);
    endtask

    task automatic load_sprite(input xcoord_t x, input xsize_t size, input logic flip,
            input page_t page, input bmp_line_t line, input word_addr_t addr, input pal_t pal);
        write_reg(REG_XPOS, {7'b0, flip, 5'b0, size, 7'b0, x});
        write_reg(REG_SRC, {7'b0, line, 8'b0, page});
        write_reg(REG_FETCH, {12'b0, pal, 9'b0, addr});
    endtask

    task automatic draw_sprite(input xcoord_t x, input xsize_t size, input logic flip,
            input page_t page, input bmp_line_t line, input word_addr_t addr, input pal_t pal);
        load_sprite(x, size, flip, page, line, addr, pal);
        ctrl_write(32'h1, RESP_OKAY);
        wait_idle();
        render_ref(x, size, flip, page, line, addr, pal);
    endtask

    task automatic clear_line();
        ctrl_write(32'h2, RESP_OKAY);
        wait_idle();
        clear_img();
    endtask

    task automatic scan_line();
        for (int i = 0; i < 512; i++) begin
            scan_addr <= xcoord_t'(i);
            scan_on   <= 1'b1;
            @(posedge clk);
        end
        scan_on <= 1'b0;
        // let the last two entries drain
        @(posedge clk);
        @(posedge clk);
    endtask

    task automatic test_done(input string name, input int err_at);
        if (errors == err_at) begin
            $display("test %-20s ok", name);
        end else begin
            $display("test %-20s failed, %0d errors", name, errors - err_at);
        end
    endtask

    initial begin
        int          err_at;
        axi_data_t   rd;
        logic [31:0] r;
        logic [31:0] r2;
        reset     = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        scan_addr = '0;
        scan_on   = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // only the defined fields read back
        err_at = errors;
        write_reg(REG_XPOS, 32'hfeda_b3c5);
        write_reg(REG_SRC, 32'h5a3c_e7a1);
        write_reg(REG_FETCH, 32'h9bc4_2ef6);
        axi_read(REG_XPOS, rd);
        check_word("rdata xpos", rd, 32'hfeda_b3c5 & 32'h0107_01ff);
        axi_read(REG_SRC, rd);
        check_word("rdata src", rd, 32'h5a3c_e7a1 & 32'h01ff_00ff);
        axi_read(REG_FETCH, rd);
        check_word("rdata fetch", rd, 32'h9bc4_2ef6 & 32'h000f_007f);
        axi_read(REG_CTRL, rd);
        check_word("rdata ctrl", rd, 32'h0);
        test_done("register readback", err_at);

        err_at = errors;
        clear_line();
        r  = $random(seed);
        r2 = $random(seed);
        draw_sprite(r[8:0], r[11:9], 1'b0, r2[7:0], {3'b0, r2[13:8]}, r2[20:14], r[15:12]);
        scan_line();
        test_done("unflipped render", err_at);

        // right edge past 511 wraps to the start of the line
        err_at = errors;
        clear_line();
        r = $random(seed);
        draw_sprite(9'd508, r[2:0], 1'b1, 8'h21, 9'h013, 7'h05, 4'h9);
        scan_line();
        test_done("flipped render", err_at);

        // page carry from the line and a word address that wraps
        err_at = errors;
        draw_sprite(9'd150, 3'd2, 1'b0, 8'hfd, 9'h1c5, 7'h7c, 4'h6);
        scan_line();
        test_done("dram addressing", err_at);

        err_at = errors;
        load_sprite(9'd40, 3'd3, 1'b1, 8'h10, 9'h0a2, 7'h30, 4'ha);
        ctrl_write(32'h1, RESP_OKAY);
        ctrl_write(32'h1, RESP_SLVERR);
        ctrl_write(32'h2, RESP_SLVERR);
        wait_idle();
        render_ref(9'd40, 3'd3, 1'b1, 8'h10, 9'h0a2, 7'h30, 4'ha);
        scan_line();
        ctrl_write(32'h2, RESP_OKAY);
        ctrl_write(32'h1, RESP_SLVERR);
        wait_idle();
        clear_img();
        ctrl_write(32'h3, RESP_SLVERR);
        axi_read(REG_CTRL, rd);
        check_word("rdata ctrl", rd, 32'h0);
        scan_line();
        test_done("busy protection", err_at);

        // second sprite overlaps the first and a clear wipes both
        err_at = errors;
        clear_line();
        draw_sprite(9'd200, 3'd3, 1'b0, 8'h42, 9'h011, 7'h10, 4'h3);
        draw_sprite(9'd220, 3'd2, 1'b1, 8'h07, 9'h02c, 7'h61, 4'hc);
        scan_line();
        clear_line();
        scan_line();
        test_done("overlap and clear", err_at);

        $display("tests %0d, checks %0d, errors %0d", TESTS, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- dv/ts_dram_model.sv
module ts_dram_model
    import ts_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dram_addr_t dram_addr,
    input  logic       dram_req,
    output dram_data_t dram_rdata,
    output logic       dram_next
);

    timeunit 1ns;
    timeprecision 100ps;

    int seed = 32'h8ae5_41ad;
    int gap;
    int wait_cnt;

    // idle port before the first clock
    initial begin
        dram_next  = 1'b0;
        dram_rdata = '0;
    end

    // contents are a fixed hash of the word address
    function automatic dram_data_t word_at(input dram_addr_t a);
        logic [31:0] prod;
        prod = {11'b0, a} * 32'h0000_9e37;
        return prod[15:0] ^ 16'h5a5a;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            dram_next  <= 1'b0;
            dram_rdata <= '0;
            wait_cnt   <= 0;
            gap        <= 4;
        end else if (!dram_req) begin
            dram_next <= 1'b0;
            wait_cnt  <= 0;
        end else if (wait_cnt >= gap) begin
            // one word per pulse followed by 4 to 7 idle cycles
            dram_next  <= 1'b1;
            dram_rdata <= word_at(dram_addr);
            wait_cnt   <= 0;
            gap        <= 4 + ($random(seed) & 3);
        end else begin
            dram_next <= 1'b0;
            wait_cnt  <= wait_cnt + 1;
        end
    end

endmodule

//--- hw/ts_line_top.sv
module ts_line_top
    import ts_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  axi_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  logic       wvalid,
    output logic       wready,
    output axi_resp_t  bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axi_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output axi_data_t  rdata,
    output axi_resp_t  rresp,
    output logic       rvalid,
    input  logic       rready,
    output dram_addr_t dram_addr,
    output logic       dram_req,
    input  dram_data_t dram_rdata,
    input  logic       dram_next,
    input  xcoord_t    scan_addr,
    output color_t     scan_data
);

    // descriptor from decode to render
    logic       go;
    logic       done;
    xcoord_t    x_coord;
    xsize_t     x_size;
    logic       x_flip;
    page_t      page;
    bmp_line_t  line;
    word_addr_t addr;
    pal_t       pal;

    // pixel writes and clear control
    xcoord_t    ts_waddr;
    color_t     ts_wdata;
    logic       ts_wr;
    logic       clear_go;
    logic       clear_busy;

    ts_sprite_decode decode (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .go         (go),
        .x_coord    (x_coord),
        .x_size     (x_size),
        .x_flip     (x_flip),
        .page       (page),
        .line       (line),
        .addr       (addr),
        .pal        (pal),
        .done       (done),
        .clear_go   (clear_go),
        .clear_busy (clear_busy)
    );

    ts_render execute (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .x_coord    (x_coord),
        .x_size     (x_size),
        .x_flip     (x_flip),
        .page       (page),
        .line       (line),
        .addr       (addr),
        .pal        (pal),
        .done       (done),
        .ts_waddr   (ts_waddr),
        .ts_wdata   (ts_wdata),
        .ts_wr      (ts_wr),
        .dram_addr  (dram_addr),
        .dram_req   (dram_req),
        .dram_rdata (dram_rdata),
        .dram_next  (dram_next)
    );

    ts_line_buf result (
        .clk        (clk),
        .reset      (reset),
        .ts_waddr   (ts_waddr),
        .ts_wdata   (ts_wdata),
        .ts_wr      (ts_wr),
        .clear_go   (clear_go),
        .clear_busy (clear_busy),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data)
    );

endmodule

//--- hw/ts_line_buf.sv
module ts_line_buf
    import ts_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  xcoord_t ts_waddr,
    input  color_t  ts_wdata,
    input  logic    ts_wr,
    input  logic    clear_go,
    output logic    clear_busy,
    input  xcoord_t scan_addr,
    output color_t  scan_data
);

    color_t       mem [512];
    clear_state_t state;
    xcoord_t      clr_addr;

    // clear sweep, one entry per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= CLR_IDLE;
            clr_addr <= '0;
        end else begin
            case (state)
                CLR_IDLE: begin
                    if (clear_go) begin
                        state    <= CLR_RUN;
                        clr_addr <= '0;
                    end
                end
                CLR_RUN: begin
                    clr_addr <= clr_addr + 1'b1;
                    // last entry written this cycle
                    if (clr_addr == 9'd511) begin
                        state <= CLR_IDLE;
                    end
                end
                default: state <= CLR_IDLE;
            endcase
        end
    end

    assign clear_busy = (state == CLR_RUN);

    // clear wins over renderer, pixel 0 is transparent
    always_ff @(posedge clk) begin
        if (state == CLR_RUN) begin
            mem[clr_addr] <= '0;
        end else if (ts_wr && ts_wdata[3:0] != 4'h0) begin
            mem[ts_waddr] <= ts_wdata;
        end
    end

    // scan out, one cycle latency
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

    a_wr_clear: assert property (@(posedge clk) disable iff (reset) ts_wr |-> !clear_busy);

endmodule

//--- hw/ts_render.sv
module ts_render
    import ts_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       go,
    input  xcoord_t    x_coord,
    input  xsize_t     x_size,
    input  logic       x_flip,
    input  page_t      page,
    input  bmp_line_t  line,
    input  word_addr_t addr,
    input  pal_t       pal,
    output logic       done,
    output xcoord_t    ts_waddr,
    output color_t     ts_wdata,
    output logic       ts_wr,
    output dram_addr_t dram_addr,
    output logic       dram_req,
    input  dram_data_t dram_rdata,
    input  logic       dram_next
);

    logic [3:0]  words_left;
    logic        last_word;
    word_addr_t  addr_reg;
    page_t       page_base;
    logic [11:0] data;
    logic [1:0]  phase;
    logic        pend;
    pix_t        pix;
    xcoord_t     x_reg;
    xcoord_t     x_start;

    // line bits 8..6 carry into the page
    assign page_base = page + page_t'(line[8:6]);
    assign dram_addr = {page_base, line[5:0], addr_reg};

    // flipped sprites start at the right edge
    assign x_start = x_flip ? x_coord + {3'b000, x_size, 3'b111} : x_coord;

    always_ff @(posedge clk) begin
        if (reset) begin
            dram_req   <= 1'b0;
            words_left <= '0;
            last_word  <= 1'b0;
            pend       <= 1'b0;
            phase      <= '0;
            done       <= 1'b0;
        end else begin
            done <= pend & (phase == 2'd3) & last_word;
            if (go) begin
                dram_req   <= 1'b1;
                // 2*(n+1) words, counted down to 0
                words_left <= {x_size, 1'b1};
            end else if (dram_next) begin
                words_left <= words_left - 1'b1;
                if (words_left == 4'd0) begin
                    dram_req  <= 1'b0;
                    last_word <= 1'b1;
                end
            end
            if (pend && phase == 2'd3 && last_word) begin
                last_word <= 1'b0;
            end
            // first nibble goes out with dram_next, three more follow
            if (dram_next) begin
                pend  <= 1'b1;
                phase <= 2'd1;
            end else if (pend) begin
                phase <= phase + 1'b1;
                if (phase == 2'd3) begin
                    pend <= 1'b0;
                end
            end
        end
    end

    // word address, x position and nibble latch
    always_ff @(posedge clk) begin
        if (go) begin
            addr_reg <= addr;
        end else if (dram_next) begin
            addr_reg <= addr_reg + 1'b1;
        end
        if (go) begin
            x_reg <= x_start;
        end else if (ts_wr) begin
            x_reg <= x_flip ? x_reg - 1'b1 : x_reg + 1'b1;
        end
        if (dram_next) begin
            data <= {dram_rdata[3:0], dram_rdata[15:8]};
        end
    end

    // nibble order 7..4, 3..0, 15..12, 11..8
    always_comb begin
        case (phase)
            2'd0:    pix = dram_rdata[7:4];
            2'd1:    pix = data[11:8];
            2'd2:    pix = data[7:4];
            default: pix = data[3:0];
        endcase
    end

    assign ts_wr    = dram_next | pend;
    assign ts_waddr = x_reg;
    assign ts_wdata = {pal, pix};

    a_next_req: assert property (@(posedge clk) disable iff (reset) dram_next |-> dram_req);
    a_next_gap: assert property (@(posedge clk) disable iff (reset) dram_next |-> !pend);

endmodule

//--- hw/ts_sprite_decode.sv
module ts_sprite_decode
    import ts_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  axi_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  logic       wvalid,
    output logic       wready,
    output axi_resp_t  bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axi_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output axi_data_t  rdata,
    output axi_resp_t  rresp,
    output logic       rvalid,
    input  logic       rready,
    output logic       go,
    output xcoord_t    x_coord,
    output xsize_t     x_size,
    output logic       x_flip,
    output page_t      page,
    output bmp_line_t  line,
    output word_addr_t addr,
    output pal_t       pal,
    input  logic       done,
    output logic       clear_go,
    input  logic       clear_busy
);

    logic      render_busy;
    logic      wr_hs;
    logic      rd_hs;
    logic      ctrl_wr;
    logic      ctrl_err;
    logic      any_busy;
    axi_data_t rd_word;

    // address and data accepted together
    assign wr_hs = awready & awvalid & wready & wvalid;
    assign rd_hs = arready & arvalid;

    // pending go or clear_go counts as busy too
    assign any_busy = render_busy | go | clear_busy | clear_go;
    assign ctrl_wr  = wr_hs & (awaddr == REG_CTRL);
    // both starts at once is a protocol error
    assign ctrl_err = any_busy | (wdata[0] & wdata[1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= RESP_OKAY;
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            go          <= 1'b0;
            clear_go    <= 1'b0;
            render_busy <= 1'b0;
        end else begin
            // one-cycle ready pulse held off while a response waits
            awready  <= awvalid & wvalid & ~bvalid & ~awready;
            wready   <= awvalid & wvalid & ~bvalid & ~awready;
            arready  <= arvalid & ~rvalid & ~arready;
            go       <= ctrl_wr & ~ctrl_err & wdata[0];
            clear_go <= ctrl_wr & ~ctrl_err & wdata[1];
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= (ctrl_wr && ctrl_err) ? RESP_SLVERR : RESP_OKAY;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // busy from go until render reports done
            if (go) begin
                render_busy <= 1'b1;
            end else if (done) begin
                render_busy <= 1'b0;
            end
        end
    end

    // descriptor registers
    always_ff @(posedge clk) begin
        if (wr_hs && awaddr == REG_XPOS) begin
            x_coord <= wdata[8:0];
            x_size  <= wdata[18:16];
            x_flip  <= wdata[24];
        end
        if (wr_hs && awaddr == REG_SRC) begin
            page <= wdata[7:0];
            line <= wdata[24:16];
        end
        if (wr_hs && awaddr == REG_FETCH) begin
            addr <= wdata[6:0];
            pal  <= wdata[19:16];
        end
        if (rd_hs) begin
            rdata <= rd_word;
        end
    end

    // readback in the write layout with status on ctrl
    always_comb begin
        case (araddr)
            REG_XPOS:  rd_word = {7'b0, x_flip, 5'b0, x_size, 7'b0, x_coord};
            REG_SRC:   rd_word = {7'b0, line, 8'b0, page};
            REG_FETCH: rd_word = {12'b0, pal, 9'b0, addr};
            REG_CTRL:  rd_word = {30'b0, clear_busy | clear_go, render_busy | go};
            default:   rd_word = '0;
        endcase
    end

    // reads never fail
    assign rresp = RESP_OKAY;

    // done only ends a render that go started
    a_done_busy: assert property (@(posedge clk) disable iff (reset) done |-> render_busy);

endmodule

//--- hw/ts_pkg.sv
package ts_pkg;

    // pixel and colour widths
    typedef logic [3:0] pix_t;
    typedef logic [3:0] pal_t;
    typedef logic [7:0] color_t;

    // sprite descriptor fields
    typedef logic [8:0] xcoord_t;
    typedef logic [2:0] xsize_t;
    typedef logic [7:0] page_t;
    typedef logic [8:0] bmp_line_t;
    typedef logic [6:0] word_addr_t;

    // dram word port
    typedef logic [20:0] dram_addr_t;
    typedef logic [15:0] dram_data_t;

    // axi4-lite register bus
    typedef logic [3:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_addr_t REG_XPOS  = 4'h0;
    localparam axi_addr_t REG_SRC   = 4'h4;
    localparam axi_addr_t REG_FETCH = 4'h8;
    localparam axi_addr_t REG_CTRL  = 4'hc;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // line buffer clear sequencer
    typedef enum logic {CLR_IDLE, CLR_RUN} clear_state_t;

endpackage
